// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // block geometry.
    localparam int block_bytes     = 16;
    localparam int words_per_block = block_bytes / 4;
    localparam int offset_width    = 4;
    localparam int line_count      = 16;
    localparam int index_width     = 4;
    localparam int tag_width       = 32 - index_width - offset_width;

    // boot address sits in flash.
    localparam logic [31:0] reset_pc = 32'h3000_0000;

    // sdram window, bounds inclusive.
    localparam logic [31:0] sdram_base = 32'hA000_0000;
    localparam logic [31:0] sdram_end  = 32'hBFFF_FFFF;

    localparam logic [3:0] axi_id_fetch  = 4'd1;
    localparam logic [2:0] axi_size_word = 3'd2;     // 4-byte beats.

    localparam logic [1:0] axi_burst_fixed = 2'd0;
    localparam logic [1:0] axi_burst_incr  = 2'd1;

    localparam logic [1:0] axi_resp_okay = 2'd0;

    // fetch controller states.
    typedef enum logic [1:0] {
        idle    = 2'd0,
        lookup  = 2'd1,
        refill  = 2'd2,
        deliver = 2'd3
    } fetch_state_t;

endpackage

// ==== hdl/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic        pc_advance,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output logic [31:0] pc
);

    logic [31:0] seq_pc;
    logic [31:0] next_pc;

    assign seq_pc = pc + 32'd4;

    // redirect wins over the sequential step.
    always_comb begin
        if (redirect_valid) begin
            next_pc = redirect_pc;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= fetch_pkg::reset_pc;
        end else if (pc_advance) begin
            pc <= next_pc;      // only on the decoder handshake.
        end
    end

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                lookup_req,
    input  logic [31:0]                         lookup_addr,
    output logic                                lookup_hit,
    output logic [31:0]                         lookup_data,

    input  logic                                fill_valid,
    input  logic [31:0]                         fill_addr,
    input  logic [fetch_pkg::block_bytes*8-1:0] fill_block
);

    logic [fetch_pkg::line_count-1:0]    valid_q;
    logic [fetch_pkg::tag_width-1:0]     tag_q [fetch_pkg::line_count];
    logic [fetch_pkg::block_bytes*8-1:0] data_q [fetch_pkg::line_count];

    logic [fetch_pkg::index_width-1:0]             lookup_index;
    logic [fetch_pkg::tag_width-1:0]               lookup_tag;
    logic [$clog2(fetch_pkg::words_per_block)-1:0] lookup_word;
    logic [fetch_pkg::block_bytes*8-1:0]           lookup_block;
    logic                                          lookup_match;

    logic [fetch_pkg::index_width-1:0] fill_index;
    logic [fetch_pkg::tag_width-1:0]   fill_tag;

    // address split.
    assign lookup_index = lookup_addr[fetch_pkg::offset_width +: fetch_pkg::index_width];
    assign lookup_tag   = lookup_addr[31 -: fetch_pkg::tag_width];
    assign lookup_word  = lookup_addr[fetch_pkg::offset_width-1:2];

    assign fill_index = fill_addr[fetch_pkg::offset_width +: fetch_pkg::index_width];
    assign fill_tag   = fill_addr[31 -: fetch_pkg::tag_width];

    assign lookup_block = data_q[lookup_index];
    assign lookup_match = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // tag and data arrays.
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_q[fill_index]  <= fill_tag;
            data_q[fill_index] <= fill_block;
        end
    end

    // registered compare, answer one cycle after the request.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lookup_hit <= 1'b0;
        end else begin
            lookup_hit <= lookup_req && lookup_match;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_req) begin
            lookup_data <= lookup_block[lookup_word*32 +: 32];
        end
    end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [31:0]                         pc,
    output logic                                pc_advance,

    output logic                                inst_valid,
    output logic [31:0]                         inst,
    output logic [31:0]                         inst_pc,
    output logic                                inst_fault,
    input  logic                                inst_ready,

    output logic                                lookup_req,
    output logic [31:0]                         lookup_addr,
    input  logic                                lookup_hit,
    input  logic [31:0]                         lookup_data,

    output logic                                fill_valid,
    output logic [31:0]                         fill_addr,
    output logic [fetch_pkg::block_bytes*8-1:0] fill_block,

    output logic [31:0]                         araddr,
    output logic                                arvalid,
    output logic [3:0]                          arid,
    output logic [7:0]                          arlen,
    output logic [2:0]                          arsize,
    output logic [1:0]                          arburst,
    input  logic                                arready,

    input  logic [31:0]                         rdata,
    input  logic [1:0]                          rresp,
    input  logic                                rlast,
    input  logic [3:0]                          rid,
    input  logic                                rvalid,
    output logic                                rready
);

    fetch_pkg::fetch_state_t state;

    logic [$clog2(fetch_pkg::words_per_block)-1:0] beat_q;
    logic [fetch_pkg::block_bytes*8-1:0]           block_q;

    logic [31:0]                                   block_base;
    logic [$clog2(fetch_pkg::words_per_block)-1:0] pc_word;
    logic                                          in_sdram;
    logic                                          result_ready;
    logic                                          beat_fire;
    logic                                          beat_ok;
    logic                                          block_done;
    logic [31:0]                                   refill_word;

    // pc only moves on pc_advance, so it stays valid for the whole fetch.
    assign lookup_addr = pc;
    assign block_base  = {pc[31:fetch_pkg::offset_width], {fetch_pkg::offset_width{1'b0}}};
    assign pc_word     = pc[fetch_pkg::offset_width-1:2];
    assign in_sdram    = (pc >= fetch_pkg::sdram_base) && (pc <= fetch_pkg::sdram_end);

    assign arid   = fetch_pkg::axi_id_fetch;
    assign arsize = fetch_pkg::axi_size_word;

    assign result_ready = (state == fetch_pkg::lookup) && !lookup_req; // hit flag is valid.

    assign beat_fire  = (state == fetch_pkg::refill) && rvalid && rready
                        && (rid == fetch_pkg::axi_id_fetch);
    assign beat_ok    = (rresp == fetch_pkg::axi_resp_okay);
    assign block_done = beat_fire && beat_ok && rlast
                        && (int'(beat_q) == fetch_pkg::words_per_block - 1);

    // cache is written in the cycle of the last beat.
    assign fill_valid = block_done;
    assign fill_addr  = block_base;

    always_comb begin
        fill_block = block_q;
        fill_block[beat_q*32 +: 32] = rdata;
    end

    assign refill_word = fill_block[pc_word*32 +: 32];

    assign pc_advance = (state == fetch_pkg::deliver) && inst_valid && inst_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= fetch_pkg::idle;
            lookup_req <= 1'b0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            inst_valid <= 1'b0;
            inst_fault <= 1'b0;
            beat_q     <= '0;
        end else begin
            case (state)
                fetch_pkg::idle: begin
                    lookup_req <= 1'b1;
                    state      <= fetch_pkg::lookup;
                end
                fetch_pkg::lookup: begin
                    lookup_req <= 1'b0;
                    if (result_ready) begin
                        if (lookup_hit) begin
                            inst_valid <= 1'b1;
                            state      <= fetch_pkg::deliver;
                        end else begin
                            arvalid <= 1'b1;
                            beat_q  <= '0;
                            state   <= fetch_pkg::refill;
                        end
                    end
                end
                fetch_pkg::refill: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (beat_fire) begin
                        if (!beat_ok) begin
                            // abort, block stays out of the cache.
                            rready     <= 1'b0;
                            inst_valid <= 1'b1;
                            inst_fault <= 1'b1;
                            state      <= fetch_pkg::deliver;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                            if (block_done) begin
                                rready     <= 1'b0;
                                inst_valid <= 1'b1;
                                state      <= fetch_pkg::deliver;
                            end else if (!in_sdram) begin
                                rready  <= 1'b0;    // next single read.
                                arvalid <= 1'b1;
                            end
                        end
                    end
                end
                fetch_pkg::deliver: begin
                    if (inst_ready) begin
                        inst_valid <= 1'b0;
                        inst_fault <= 1'b0;
                        state      <= fetch_pkg::idle;
                    end
                end
                default: state <= fetch_pkg::idle;
            endcase
        end
    end

    // payload, block buffer and AR fields.
    always_ff @(posedge clk) begin
        if (result_ready) begin
            inst    <= lookup_data;
            inst_pc <= pc;
            araddr  <= block_base;
            if (in_sdram) begin
                arlen   <= 8'(fetch_pkg::words_per_block - 1);
                arburst <= fetch_pkg::axi_burst_incr;
            end else begin
                arlen   <= 8'd0;
                arburst <= fetch_pkg::axi_burst_fixed;
            end
        end
        if (beat_fire) begin
            block_q[beat_q*32 +: 32] <= rdata;
            if (!beat_ok) begin
                inst <= '0;
            end else if (block_done) begin
                inst <= refill_word;
            end else if (!in_sdram) begin
                araddr <= araddr + 32'd4;
            end
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic        clk,
    input  logic        rst,

    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,

    output logic        inst_valid,
    output logic [31:0] inst,
    output logic [31:0] inst_pc,
    output logic        inst_fault,
    input  logic        inst_ready,

    output logic [31:0] araddr,
    output logic        arvalid,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    input  logic        arready,

    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid,
    input  logic        rvalid,
    output logic        rready
);

    logic [31:0] pc;
    logic        pc_advance;

    // cache ports.
    logic                                lookup_req;
    logic [31:0]                         lookup_addr;
    logic                                lookup_hit;
    logic [31:0]                         lookup_data;
    logic                                fill_valid;
    logic [31:0]                         fill_addr;
    logic [fetch_pkg::block_bytes*8-1:0] fill_block;

    fetch_pc_gen pc_gen_i (
        .clk            (clk),
        .rst            (rst),
        .pc_advance     (pc_advance),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (pc)
    );

    fetch_unit fetch_i (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .pc_advance  (pc_advance),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_fault  (inst_fault),
        .inst_ready  (inst_ready),
        .lookup_req  (lookup_req),
        .lookup_addr (lookup_addr),
        .lookup_hit  (lookup_hit),
        .lookup_data (lookup_data),
        .fill_valid  (fill_valid),
        .fill_addr   (fill_addr),
        .fill_block  (fill_block),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arid        (arid),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rid         (rid),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    icache icache_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_req  (lookup_req),
        .lookup_addr (lookup_addr),
        .lookup_hit  (lookup_hit),
        .lookup_data (lookup_data),
        .fill_valid  (fill_valid),
        .fill_addr   (fill_addr),
        .fill_block  (fill_block)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    // release just after an edge, like the other inputs.
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== tests/axi_rom_model.sv ====
`timescale 1ns/1ps

module axi_rom_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    input  logic [7:0]  arlen,
    input  logic [1:0]  arburst,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic [3:0]  rid,
    output logic        rvalid,
    input  logic        rready,
    output int          ar_count,
    output logic        protocol_error
);

    localparam logic [1:0] resp_slverr = 2'd2;

    integer      seed = 32'h3703_8391;
    logic [31:0] roll;
    logic        in_reset;
    logic        beat_taken;
    logic [31:0] beat_addr;
    logic [1:0]  beat_burst;
    int          beats_left;
    logic        ar_held;
    logic [31:0] held_addr;
    logic [7:0]  held_len;
    logic [1:0]  held_burst;

    task automatic flag_violation(input string what);
        $display("axi read slave: %s at %0t", what, $time);
        protocol_error <= 1'b1;
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = '0;
        rlast   = 1'b0;
        rid     = '0;
        ar_count       <= 0;
        protocol_error <= 1'b0;
        beats_left = 0;
        ar_held    = 1'b0;
        forever begin
            @(posedge clk);
            in_reset   = rst;
            beat_taken = rvalid && rready;
            if (in_reset) begin
                beats_left = 0;
                ar_held    = 1'b0;
            end else begin
                if (ar_held) begin
                    assert (arvalid && araddr == held_addr && arlen == held_len
                            && arburst == held_burst)
                    else flag_violation("AR request changed before arready");
                end
                assert (!rready || beats_left > 0)
                else flag_violation("rready raised with no read outstanding");
                if (arvalid && arready) begin
                    ar_count  <= ar_count + 1;
                    beat_addr  = araddr;
                    beat_burst = arburst;
                    beats_left = int'(arlen) + 1;
                end
                if (beat_taken) begin
                    // an error beat ends the burst.
                    beats_left = (rresp == fetch_pkg::axi_resp_okay) ? beats_left - 1 : 0;
                    if (beat_burst == fetch_pkg::axi_burst_incr) begin
                        beat_addr = beat_addr + 32'd4;
                    end
                end
                ar_held    = arvalid && !arready;
                held_addr  = araddr;
                held_len   = arlen;
                held_burst = arburst;
            end
            #1;
            roll    = $random(seed);
            arready = !in_reset && beats_left == 0 && roll[0];
            if (in_reset || beats_left == 0) begin
                rvalid = 1'b0;
            end else if (!rvalid || beat_taken) begin
                rvalid = roll[2:1] != 2'b00;    // random gaps between beats.
                rid    = fetch_pkg::axi_id_fetch;
                rlast  = beats_left == 1;
                if (beat_addr[31:16] == 16'h4000) begin
                    rresp = resp_slverr;
                    rdata = '0;
                end else begin
                    rresp = fetch_pkg::axi_resp_okay;
                    rdata = beat_addr ^ 32'h5A5A_5A5A;
                end
            end
        end
    end

endmodule

// ==== tests/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int          max_cycles = 20000;     // ~40 fetches at 400 cycles worst case.
    localparam logic [31:0] data_key   = 32'h5A5A_5A5A;
    localparam logic [31:0] fault_base = 32'h4000_0000;

    logic        clk;
    logic        rst;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        inst_fault;
    logic        inst_ready;
    logic [31:0] araddr;
    logic        arvalid;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic [3:0]  rid;
    logic        rvalid;
    logic        rready;
    int          ar_count;
    logic        protocol_error;

    integer      seed = 32'h3703_8391;
    int          cycle_count = 0;
    logic [31:0] exp_pc;
    int          ar_mark;
    logic        was_reset;
    logic        held_valid;
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    logic        held_fault;

    // expected cache contents as one block address per line.
    logic [fetch_pkg::line_count-1:0]    ref_valid;
    logic [31-fetch_pkg::offset_width:0] ref_block [fetch_pkg::line_count];

    tb_clock clock_i (.*);
    fetch_top dut_i (.*);
    axi_rom_model rom_i (.*);

    function automatic logic in_fault_window(input logic [31:0] addr);
        return addr[31:16] == fault_base[31:16];
    endfunction

    function automatic logic in_sdram(input logic [31:0] addr);
        return addr >= fetch_pkg::sdram_base && addr <= fetch_pkg::sdram_end;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, want));
    endtask

    task automatic check_read_request();
        logic [31:0] base;
        logic [31:0] want_addr;
        base      = {exp_pc[31:fetch_pkg::offset_width], {fetch_pkg::offset_width{1'b0}}};
        want_addr = base + 32'(4 * (ar_count - ar_mark));   // single reads walk the block.
        assert (arid == fetch_pkg::axi_id_fetch)
        else flag_mismatch("arid", 32'(arid), 32'(fetch_pkg::axi_id_fetch));
        assert (arsize == fetch_pkg::axi_size_word)
        else flag_mismatch("arsize", 32'(arsize), 32'(fetch_pkg::axi_size_word));
        if (in_sdram(exp_pc)) begin
            assert (araddr == base) else flag_mismatch("araddr", araddr, base);
            assert (arlen == 8'd3) else flag_mismatch("arlen", 32'(arlen), 32'd3);
            assert (arburst == fetch_pkg::axi_burst_incr)
            else flag_mismatch("arburst", 32'(arburst), 32'(fetch_pkg::axi_burst_incr));
        end else begin
            assert (araddr == want_addr) else flag_mismatch("araddr", araddr, want_addr);
            assert (arlen == 8'd0) else flag_mismatch("arlen", 32'(arlen), 32'd0);
            assert (arburst == fetch_pkg::axi_burst_fixed)
            else flag_mismatch("arburst", 32'(arburst), 32'(fetch_pkg::axi_burst_fixed));
        end
    endtask

    task automatic check_delivery();
        logic [fetch_pkg::index_width-1:0] index;
        logic                              hit;
        logic                              fault;
        int                                want_reads;
        index = exp_pc[fetch_pkg::offset_width +: fetch_pkg::index_width];
        hit   = ref_valid[index] && ref_block[index] == exp_pc[31:fetch_pkg::offset_width];
        fault = in_fault_window(exp_pc);
        if (hit) begin
            want_reads = 0;
        end else if (fault || in_sdram(exp_pc)) begin
            want_reads = 1;
        end else begin
            want_reads = fetch_pkg::words_per_block;
        end
        assert (inst_pc == exp_pc) else flag_mismatch("inst_pc", inst_pc, exp_pc);
        assert (inst_fault == fault) else flag_mismatch("inst_fault", 32'(inst_fault), 32'(fault));
        if (!fault) begin
            assert (inst == (exp_pc ^ data_key)) else flag_mismatch("inst", inst, exp_pc ^ data_key);
        end
        assert (ar_count - ar_mark == want_reads)
        else flag_mismatch("AR handshake count", 32'(ar_count - ar_mark), 32'(want_reads));
        if (!hit && !fault) begin
            ref_valid[index] = 1'b1;    // faulted blocks never land.
            ref_block[index] = exp_pc[31:fetch_pkg::offset_width];
        end
        ar_mark = ar_count;
        exp_pc  = redirect_valid ? redirect_pc : exp_pc + 32'd4;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles) begin
            abort_run($sformatf("timeout: run still going after %0d cycles", max_cycles));
        end
    end

    // checks on pre-edge values; inputs move 1 ns after the edge.
    always @(posedge clk) begin
        assert (!protocol_error) else abort_run("AXI read slave saw a protocol violation");
        if (rst || was_reset) begin
            assert (!inst_valid && !arvalid && !rready)
            else abort_run("control outputs active during or right after reset");
        end
        if (rst) begin
            exp_pc     = fetch_pkg::reset_pc;
            ar_mark    = 0;
            ref_valid  = '0;
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                assert (inst_valid) else abort_run("inst_valid dropped before the handshake");
                assert (inst == held_inst) else flag_mismatch("inst", inst, held_inst);
                assert (inst_pc == held_pc) else flag_mismatch("inst_pc", inst_pc, held_pc);
                assert (inst_fault == held_fault)
                else flag_mismatch("inst_fault", 32'(inst_fault), 32'(held_fault));
            end
            if (inst_valid) begin
                assert (!arvalid) else abort_run("AR issued while an instruction waits");
            end
            if (arvalid && arready) begin
                check_read_request();
            end
            if (inst_valid && inst_ready) begin
                check_delivery();
            end
            held_valid = inst_valid && !inst_ready;
            held_inst  = inst;
            held_pc    = inst_pc;
            held_fault = inst_fault;
        end
        was_reset = rst;
    end

    // the last fetch of each run carries the redirect.
    task automatic run_fetches(input int count, input logic [31:0] target, input int stall_max);
        int stall;
        for (int i = 0; i < count; i++) begin
            redirect_valid = (i == count - 1);
            redirect_pc    = target;
            do begin
                @(posedge clk);
                #1;
            end while (!inst_valid);
            stall = ($random(seed) & 32'h7fff_ffff) % (stall_max + 1);
            repeat (stall) begin
                @(posedge clk);
                #1;
            end
            inst_ready = 1'b1;
            @(posedge clk);
            #1;
            inst_ready = 1'b0;
        end
        redirect_valid = 1'b0;
    endtask

    initial begin
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        inst_ready     = 1'b0;
        @(negedge rst);
        run_fetches(8, 32'hA000_0040, 0);       // two flash blocks.
        run_fetches(8, fetch_pkg::reset_pc, 0); // sdram bursts.
        run_fetches(4, fault_base, 0);          // first block still cached.
        run_fetches(1, fault_base, 0);
        run_fetches(1, 32'h3000_0100, 0);       // fault again without a fill.
        run_fetches(8, 32'h4000_0010, 6);       // back-pressure from here on.
        run_fetches(1, 32'hA000_0200, 6);
        run_fetches(4, fetch_pkg::reset_pc, 6);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
tests/tb_clock.sv
tests/axi_rom_model.sv
tests/tb_fetch_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_top \
    -f sim.f -o tb_fetch_top_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_fetch_top_sim > sim.log 2>&1
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
